/* rtl/gyruss_macros.svh */
// Raster, divider and memory sizes shared by the packages and the RTL; the raster has no centring
`ifndef GYRUSS_MACROS_SVH
`define GYRUSS_MACROS_SVH

// =========================================================================
// Raster
// =========================================================================

// Pixels per line and the visible part
`define H_TOTAL      384
`define H_VISIBLE    256
// Horizontal sync low window, in pixels
`define HSYNC_START  296
`define HSYNC_END    328

// Lines per frame and the visible part
`define V_TOTAL      264
`define V_VISIBLE    224
// Vertical sync low window, in lines
`define VSYNC_START  240
`define VSYNC_END    248

// Master clocks per pixel
`define PIX_DIV      8

// =========================================================================
// Memory address widths
// =========================================================================
`define VRAM_AW      11
`define TROM_AW      13
`define LUT_AW       6
`define CPROM_AW     5

`endif

/* rtl/video_pkg.sv */
// Video types for the tile path; counter widths are taken from the raster totals in the macro header
`include "gyruss_macros.svh"

package video_pkg;

	// Raster counters, wide enough for the full line and frame totals
	// 264 lines need a ninth bit on the vertical count
	typedef logic [$clog2(`H_TOTAL)-1:0] hcnt_t;
	typedef logic [$clog2(`V_TOTAL)-1:0] vcnt_t;

	// Two bitplane pixel out of the shifter
	typedef logic [1:0] pix2_t;
	// Lookup PROM output nibble
	typedef logic [3:0] lut_t;
	// Colour PROM index
	typedef logic [`CPROM_AW-1:0] cidx_t;

	// Attribute byte from the upper half of VRAM
	typedef struct packed {
		logic       vflip;
		logic       hflip;
		logic       bank;
		logic       prio;
		logic [3:0] colour;
	} tile_attr_t;

	// Colour PROM byte layout, 8 bits per pixel
	typedef struct packed {
		logic [1:0] blue;
		logic [2:0] green;
		logic [2:0] red;
	} rgb_t;

	// Everything the video blocks need from the timing chain
	typedef struct packed {
		hcnt_t h;
		vcnt_t v;
		logic  cen;
		logic  hblank;
		logic  vblank;
	} timing_t;

endpackage

/* rtl/bus_pkg.sv */
// Host write and ROM download bus types; both are single clock strobes with no handshake
`include "gyruss_macros.svh"

package bus_pkg;

	// Host write
	// Top address bit picks the flip latch, the rest addresses VRAM
	typedef struct packed {
		logic [`VRAM_AW:0] addr;
		logic [7:0]        data;
		logic              wr;
	} host_wr_t;

	// ROM download, address sized for the largest ROM
	// Smaller ROMs use the low address and data bits
	typedef struct packed {
		logic [`TROM_AW-1:0] addr;
		logic [7:0]          data;
		logic                wr;
	} dl_bus_t;

endpackage

/* rtl/dl_rom.sv */
// Registered read ROM loaded by download strobes; contents are undefined until loaded, ADDR_W <= 13
`timescale 1ns/10ps

module dl_rom #(
	parameter int ADDR_W = 13,
	parameter int DATA_W = 8
) (
	input  logic              clk_49m,
	input  bus_pkg::dl_bus_t  dl_i,
	input  logic              cs_i,
	input  logic [ADDR_W-1:0] addr_i,
	output logic [DATA_W-1:0] data_o
);

	logic [DATA_W-1:0] mem [2**ADDR_W];

	// Download port shares the clock with the read side
	// Narrow ROMs keep only the low data bits
	always_ff @(posedge clk_49m) begin
		if (dl_i.wr && cs_i) begin
			mem[dl_i.addr[ADDR_W-1:0]] <= dl_i.data[DATA_W-1:0];
		end
		// Data follows the address one clock later
		data_o <= mem[addr_i];
	end

endmodule

/* rtl/video_timing.sv */
// Fixed 384x264 raster with no centring; cen marks the last master clock of each pixel
`timescale 1ns/10ps
`include "gyruss_macros.svh"

module video_timing (
	input  logic               clk_49m,
	input  logic               reset,
	output video_pkg::timing_t timing_o,
	output logic               hsync_n_o,
	output logic               vsync_n_o
);
	import video_pkg::*;

	localparam int DIV_W = $clog2(`PIX_DIV);
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`PIX_DIV - 1);
	localparam hcnt_t H_LAST   = hcnt_t'(`H_TOTAL - 1);
	localparam hcnt_t H_VIS    = hcnt_t'(`H_VISIBLE);
	localparam hcnt_t HS_START = hcnt_t'(`HSYNC_START);
	localparam hcnt_t HS_END   = hcnt_t'(`HSYNC_END);
	localparam vcnt_t V_LAST   = vcnt_t'(`V_TOTAL - 1);
	localparam vcnt_t V_VIS    = vcnt_t'(`V_VISIBLE);
	localparam vcnt_t VS_START = vcnt_t'(`VSYNC_START);
	localparam vcnt_t VS_END   = vcnt_t'(`VSYNC_END);

	logic [DIV_W-1:0] div_q;
	logic             cen;
	hcnt_t            h_q;
	vcnt_t            v_q;

	// =========================================================================
	// Pixel clock enable
	// =========================================================================
	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			div_q <= '0;
		end else if (div_q == DIV_LAST) begin
			div_q <= '0;
		end else begin
			div_q <= div_q + 1'b1;
		end
	end

	// One clock in PIX_DIV, on the last phase
	assign cen = (div_q == DIV_LAST);

	// =========================================================================
	// Raster counters
	// =========================================================================
	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			h_q <= '0;
			v_q <= '0;
		end else if (cen) begin
			if (h_q == H_LAST) begin
				h_q <= '0;
				// Line count steps at the end of each line
				if (v_q == V_LAST) begin
					v_q <= '0;
				end else begin
					v_q <= v_q + 1'b1;
				end
			end else begin
				h_q <= h_q + 1'b1;
			end
		end
	end

	// Syncs are registered, so they trail the counters by a master clock
	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			hsync_n_o <= 1'b1;
			vsync_n_o <= 1'b1;
		end else begin
			hsync_n_o <= !(h_q >= HS_START && h_q < HS_END);
			vsync_n_o <= !(v_q >= VS_START && v_q < VS_END);
		end
	end

	// Blanks follow the counters directly
	assign timing_o.h      = h_q;
	assign timing_o.v      = v_q;
	assign timing_o.cen    = cen;
	assign timing_o.hblank = (h_q >= H_VIS);
	assign timing_o.vblank = (v_q >= V_VIS);

endmodule

/* rtl/host_bus.sv */
// One write is held at a time; host writes must be at least 32 clocks apart or the held one is lost
`timescale 1ns/10ps
`include "gyruss_macros.svh"

module host_bus (
	input  logic               clk_49m,
	input  logic               reset,
	input  video_pkg::timing_t timing_i,
	input  bus_pkg::host_wr_t  host_i,
	output bus_pkg::host_wr_t  vram_wr_o,
	output logic               flip_o
);

	localparam int PH_W = $clog2(`PIX_DIV);
	// Host slot sits halfway through the pixel, clear of the tile fetch
	localparam logic [PH_W-1:0] HOST_SLOT = PH_W'(`PIX_DIV / 2);

	logic [PH_W-1:0]     phase_q;
	logic                sel_flip;
	logic                pend_q;
	logic [`VRAM_AW-1:0] addr_q;
	logic [7:0]          data_q;

	assign sel_flip = host_i.addr[`VRAM_AW];

	// Master clock phase within the pixel, zero on the clock after cen
	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			phase_q <= '0;
		end else begin
			phase_q <= timing_i.cen ? '0 : phase_q + 1'b1;
		end
	end

	// Flip latch takes data bit 0 straight away
	// VRAM writes wait for the host slot
	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			pend_q <= 1'b0;
			flip_o <= 1'b0;
		end else begin
			if (host_i.wr && sel_flip) begin
				flip_o <= host_i.data[0];
			end
			if (host_i.wr && !sel_flip) begin
				pend_q <= 1'b1;
			end else if (phase_q == HOST_SLOT) begin
				pend_q <= 1'b0;
			end
		end
	end

	// Held address and data
	always_ff @(posedge clk_49m) begin
		if (host_i.wr && !sel_flip) begin
			addr_q <= host_i.addr[`VRAM_AW-1:0];
			data_q <= host_i.data;
		end
	end

	assign vram_wr_o.addr = {1'b0, addr_q};
	assign vram_wr_o.data = data_q;
	assign vram_wr_o.wr   = pend_q && (phase_q == HOST_SLOT);

endmodule

/* rtl/tile_layer.sv */
// Tile fetch runs one tile ahead of the counter; VRAM reads use phases 0 and 2 and writes only phase 4
`timescale 1ns/10ps
`include "gyruss_macros.svh"

module tile_layer (
	input  logic                clk_49m,
	input  logic                reset,
	input  video_pkg::timing_t  timing_i,
	input  logic                flip_i,
	input  bus_pkg::host_wr_t   vram_wr_i,
	output logic [`TROM_AW-1:0] trom_a_o,
	input  logic [7:0]          trom_d_i,
	output logic [`LUT_AW-1:0]  lut_a_o,
	output logic                prio_o
);
	import video_pkg::*;

	localparam int PH_W = $clog2(`PIX_DIV);
	localparam logic [PH_W-1:0] PH_CODE   = PH_W'(0);
	localparam logic [PH_W-1:0] PH_CODE_Q = PH_W'(1);
	localparam logic [PH_W-1:0] PH_ATTR   = PH_W'(2);
	localparam logic [PH_W-1:0] PH_ATTR_Q = PH_W'(3);
	localparam hcnt_t FETCH_WRAP = hcnt_t'(`H_TOTAL - 8);
	localparam hcnt_t H_AHEAD    = hcnt_t'(8);
	localparam vcnt_t V_LAST     = vcnt_t'(`V_TOTAL - 1);

	logic [7:0]          vram [2**`VRAM_AW];
	logic [7:0]          vram_q;
	logic [PH_W-1:0]     phase_q;
	hcnt_t               fh;
	vcnt_t               fv;
	logic [7:0]          fcol;
	logic [7:0]          fline;
	logic [`VRAM_AW-1:0] rd_addr;
	logic                fetch_pix;
	tile_attr_t          attr_w;
	logic [7:0]          code_l;
	tile_attr_t          attr_l;
	logic [2:0]          line_l;
	logic                rev_l;
	logic                half;
	logic                load;
	logic [7:0]          rom_byte;
	logic [7:0]          sh_q;
	logic [3:0]          colour_q;
	logic                prio_q;
	pix2_t               pix;

	// Phase within the pixel, in step with the timing divider
	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			phase_q <= '0;
		end else begin
			phase_q <= timing_i.cen ? '0 : phase_q + 1'b1;
		end
	end

	// =========================================================================
	// Fetch address
	// =========================================================================

	// Fetch position is 8 pixels ahead, wrapping into the next line
	always_comb begin
		if (timing_i.h >= FETCH_WRAP) begin
			fh = timing_i.h - FETCH_WRAP;
			fv = (timing_i.v == V_LAST) ? '0 : timing_i.v + 1'b1;
		end else begin
			fh = timing_i.h + H_AHEAD;
			fv = timing_i.v;
		end
	end

	// Screen flip inverts both axes
	assign fcol  = fh[7:0] ^ {8{flip_i}};
	assign fline = fv[7:0] ^ {8{flip_i}};
	// Code from the lower half at phase 0, attribute from the upper half at phase 2
	assign rd_addr = {phase_q[1], fline[7:3], fcol[7:3]};
	// Fetch happens once per tile, halfway through
	assign fetch_pix = (timing_i.h[2:0] == 3'd4);

	always_ff @(posedge clk_49m) begin
		if (vram_wr_i.wr) begin
			vram[vram_wr_i.addr[`VRAM_AW-1:0]] <= vram_wr_i.data;
		end
		if (phase_q == PH_CODE || phase_q == PH_ATTR) begin
			vram_q <= vram[rd_addr];
		end
	end

	assign attr_w = vram_q;

	// Code and line first, attribute two clocks later
	// These hold the next tile until pixel 3 of that tile
	always_ff @(posedge clk_49m) begin
		if (fetch_pix && phase_q == PH_CODE_Q) begin
			code_l <= vram_q;
			line_l <= fline[2:0];
		end
		if (fetch_pix && phase_q == PH_ATTR_Q) begin
			attr_l <= attr_w;
			rev_l  <= attr_w.hflip ^ flip_i;
		end
	end

	// =========================================================================
	// Tile ROM and shifter
	// =========================================================================

	// Left half is read in pixel 7 ahead of the tile, right half in its pixel 3
	assign half     = rev_l ^ ~timing_i.h[2];
	assign trom_a_o = {attr_l.bank, code_l, half, line_l ^ {3{attr_l.vflip}}};

	assign load = timing_i.cen && (timing_i.h[1:0] == 2'b11);
	// Reversed tiles load each bitplane nibble mirrored so the shifter always shifts right
	assign rom_byte = rev_l ?
		{trom_d_i[4], trom_d_i[5], trom_d_i[6], trom_d_i[7],
		 trom_d_i[0], trom_d_i[1], trom_d_i[2], trom_d_i[3]} : trom_d_i;

	always_ff @(posedge clk_49m) begin
		if (load) begin
			sh_q <= rom_byte;
		end else if (timing_i.cen) begin
			sh_q <= {1'b0, sh_q[7:5], 1'b0, sh_q[3:1]};
		end
	end

	assign pix = {sh_q[4], sh_q[0]};

	// Colour and priority change with the shifter load, in line with the first pixel
	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			prio_q <= 1'b0;
		end else if (load) begin
			prio_q <= attr_l.prio;
		end
	end

	always_ff @(posedge clk_49m) begin
		if (load) begin
			colour_q <= attr_l.colour;
		end
	end

	assign lut_a_o = {colour_q, pix};
	assign prio_o  = prio_q;

endmodule

/* rtl/color_output.sv */
// Colour PROM output stage; PROM entry 0 is the background shown where tiles have priority clear
`timescale 1ns/10ps

module color_output (
	input  logic               clk_49m,
	input  logic               reset,
	input  video_pkg::timing_t timing_i,
	input  logic               prio_i,
	input  video_pkg::lut_t    lut_d_i,
	output video_pkg::cidx_t   cprom_a_o,
	input  video_pkg::rgb_t    cprom_d_i,
	output video_pkg::rgb_t    rgb_o
);

	logic blank;

	// Tile colours in the upper half of the PROM
	// Lower half held the sprite colours, only entry 0 is still used
	assign cprom_a_o = prio_i ? {1'b1, lut_d_i} : '0;

	// Blank for the column being loaded
	assign blank = timing_i.hblank || timing_i.vblank;

	// PROM data has settled well before the end of the pixel
	// Load on cen, black outside the visible area
	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			rgb_o <= '0;
		end else if (timing_i.cen) begin
			if (blank) begin
				rgb_o <= '0;
			end else begin
				rgb_o <= cprom_d_i;
			end
		end
	end

endmodule

/* rtl/gyruss_video_top.sv */
// Tile-only video path; the picture is meaningful once all three ROMs are downloaded and a frame has run
`timescale 1ns/10ps
`include "gyruss_macros.svh"

module gyruss_video_top (
	input  logic              clk_49m,
	input  logic              reset,
	input  bus_pkg::host_wr_t host_i,
	input  bus_pkg::dl_bus_t  dl_i,
	input  logic              trom_cs_i,
	input  logic              tlut_cs_i,
	input  logic              cprom_cs_i,
	output video_pkg::rgb_t   rgb_o,
	output logic              hsync_n_o,
	output logic              vsync_n_o,
	output logic              hblank_o,
	output logic              vblank_o,
	output logic              ce_pix_o
);
	import video_pkg::*;
	import bus_pkg::*;

	timing_t             timing;
	host_wr_t            vram_wr;
	logic                flip;
	logic [`TROM_AW-1:0] trom_a;
	logic [7:0]          trom_d;
	logic [`LUT_AW-1:0]  lut_a;
	lut_t                lut_d;
	logic                prio;
	cidx_t               cprom_a;
	rgb_t                cprom_d;

	video_timing u_timing (
		.clk_49m   (clk_49m),
		.reset     (reset),
		.timing_o  (timing),
		.hsync_n_o (hsync_n_o),
		.vsync_n_o (vsync_n_o)
	);

	host_bus u_host (
		.clk_49m   (clk_49m),
		.reset     (reset),
		.timing_i  (timing),
		.host_i    (host_i),
		.vram_wr_o (vram_wr),
		.flip_o    (flip)
	);

	tile_layer u_tile (
		.clk_49m   (clk_49m),
		.reset     (reset),
		.timing_i  (timing),
		.flip_i    (flip),
		.vram_wr_i (vram_wr),
		.trom_a_o  (trom_a),
		.trom_d_i  (trom_d),
		.lut_a_o   (lut_a),
		.prio_o    (prio)
	);

	// =========================================================================
	// Downloadable ROMs
	// =========================================================================

	// Tile graphics, two bitplanes per byte
	dl_rom #(.ADDR_W(`TROM_AW), .DATA_W(8)) u_trom (
		.clk_49m (clk_49m),
		.dl_i    (dl_i),
		.cs_i    (trom_cs_i),
		.addr_i  (trom_a),
		.data_o  (trom_d)
	);

	// Tile lookup PROM
	dl_rom #(.ADDR_W(`LUT_AW), .DATA_W(4)) u_tlut (
		.clk_49m (clk_49m),
		.dl_i    (dl_i),
		.cs_i    (tlut_cs_i),
		.addr_i  (lut_a),
		.data_o  (lut_d)
	);

	// Colour PROM
	dl_rom #(.ADDR_W(`CPROM_AW), .DATA_W(8)) u_cprom (
		.clk_49m (clk_49m),
		.dl_i    (dl_i),
		.cs_i    (cprom_cs_i),
		.addr_i  (cprom_a),
		.data_o  (cprom_d)
	);

	color_output u_color (
		.clk_49m   (clk_49m),
		.reset     (reset),
		.timing_i  (timing),
		.prio_i    (prio),
		.lut_d_i   (lut_d),
		.cprom_a_o (cprom_a),
		.cprom_d_i (cprom_d),
		.rgb_o     (rgb_o)
	);

	// Blank outputs load on the same cen as rgb_o so the two stay in step
	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			hblank_o <= 1'b0;
			vblank_o <= 1'b0;
		end else if (timing.cen) begin
			hblank_o <= timing.hblank;
			vblank_o <= timing.vblank;
		end
	end

	assign ce_pix_o = timing.cen;

endmodule

/* sim/tb_clock.sv */
// Free running 20 ns clock; reset is held low for the first 3 rising edges and then released for good
`timescale 1ns/10ps

module tb_clock (
	output logic clk_49m_o,
	output logic reset_o
);

	// Half period of 10 ns
	initial begin
		clk_49m_o = 1'b0;
		forever #10 clk_49m_o = ~clk_49m_o;
	end

	// Active low reset, released on a rising edge
	initial begin
		reset_o = 1'b0;
		repeat (3) @(posedge clk_49m_o);
		reset_o <= 1'b1;
	end

endmodule

/* sim/gyruss_sva.sv */
// Bound to the video top level; checks pixel enable spacing, blanking to black and syncs under reset
`timescale 1ns/10ps
`include "gyruss_macros.svh"

module gyruss_sva (
	input logic            clk_49m,
	input logic            reset,
	input logic            ce_pix_o,
	input video_pkg::rgb_t rgb_o,
	input logic            hblank_o,
	input logic            vblank_o,
	input logic            hsync_n_o,
	input logic            vsync_n_o
);

	// Clocks since the last pixel enable
	int gap_q;

	always_ff @(posedge clk_49m) begin
		if (!reset || ce_pix_o) begin
			gap_q <= 0;
		end else begin
			gap_q <= gap_q + 1;
		end
	end

	// =========================================================================
	// Properties
	// =========================================================================

	// Enable comes back every PIX_DIV clocks, never early or late
	ce_spacing: assert property (@(posedge clk_49m) disable iff (!reset)
		ce_pix_o |-> gap_q == `PIX_DIV - 1)
		else $error("pixel enable spacing wrong");

	ce_no_late: assert property (@(posedge clk_49m) disable iff (!reset)
		gap_q < `PIX_DIV)
		else $error("pixel enable missing");

	// Blanked pixels are black
	blank_black: assert property (@(posedge clk_49m) disable iff (!reset)
		(hblank_o || vblank_o) |-> rgb_o == '0)
		else $error("rgb not black in blanking");

	// Syncs idle high once a reset edge has passed
	sync_reset: assert property (@(posedge clk_49m)
		!reset |=> (hsync_n_o && vsync_n_o))
		else $error("sync low during reset");

endmodule

/* sim/tb_top.sv */
// Loads all ROMs and the whole VRAM through the host port first; checks three frames, bounded by a watchdog
`timescale 1ns/10ps
`include "gyruss_macros.svh"

bind gyruss_video_top gyruss_sva u_sva (
	.clk_49m   (clk_49m),
	.reset     (reset),
	.ce_pix_o  (ce_pix_o),
	.rgb_o     (rgb_o),
	.hblank_o  (hblank_o),
	.vblank_o  (vblank_o),
	.hsync_n_o (hsync_n_o),
	.vsync_n_o (vsync_n_o)
);

module tb_top;
	import video_pkg::*;
	import bus_pkg::*;

	localparam int     CLK_NS     = 20;
	localparam int     FRAME_CLKS = `PIX_DIV * `H_TOTAL * `V_TOTAL;
	// Setup fits in the first frame, the checks need at most four more
	localparam longint WATCHDOG   = 64'(6) * FRAME_CLKS * CLK_NS;
	localparam int     MAX_PRINT  = 20;
	localparam int     HOST_LINE  = 230;

	logic     clk_49m;
	logic     reset;
	host_wr_t host;
	dl_bus_t  dl;
	logic     trom_cs;
	logic     tlut_cs;
	logic     cprom_cs;
	rgb_t     rgb;
	logic     hsync_n;
	logic     vsync_n;
	logic     hblank;
	logic     vblank;
	logic     ce_pix;

	// Shadow copies of everything the DUT holds
	logic [7:0] vram_sh [2**`VRAM_AW];
	logic [7:0] trom_sh [2**`TROM_AW];
	logic [3:0] tlut_sh [2**`LUT_AW];
	rgb_t       cprom_sh [2**`CPROM_AW];
	logic       flip_sh;
	logic [31:0] rng;

	// Raster mirror and error counts
	int cur_h, cur_v, smp_h, smp_v;
	bit smp_valid, ce_seen, cens_valid;
	int clk_gap, frame_cens, frame_cnt, chk_start;
	logic vsync_prev;
	int frame_errs [16];
	int timing_errs, blank_errs, reset_errs, prio0_cnt, prio0_errs, printed;
	int tests_passed, tests_failed;

	tb_clock u_clock (
		.clk_49m_o (clk_49m),
		.reset_o   (reset)
	);

	gyruss_video_top dut (
		.clk_49m    (clk_49m),
		.reset      (reset),
		.host_i     (host),
		.dl_i       (dl),
		.trom_cs_i  (trom_cs),
		.tlut_cs_i  (tlut_cs),
		.cprom_cs_i (cprom_cs),
		.rgb_o      (rgb),
		.hsync_n_o  (hsync_n),
		.vsync_n_o  (vsync_n),
		.hblank_o   (hblank),
		.vblank_o   (vblank),
		.ce_pix_o   (ce_pix)
	);

	// =========================================================================
	// Reference model
	// =========================================================================

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Attribute byte of the tile under a screen position
	function automatic tile_attr_t attr_at(input int col, input int line, input logic fl);
		logic [7:0] c;
		logic [7:0] l;
		c = col[7:0] ^ {8{fl}};
		l = line[7:0] ^ {8{fl}};
		return vram_sh[{1'b1, l[7:3], c[7:3]}];
	endfunction

	function automatic rgb_t ref_rgb(input int col, input int line, input logic fl);
		logic [7:0] c;
		logic [7:0] l;
		logic [7:0] code;
		logic [7:0] rb;
		tile_attr_t attr;
		logic [2:0] px;
		logic [2:0] ln;
		logic [1:0] pix;
		logic [3:0] lut;
		logic [4:0] idx;
		if (col >= `H_VISIBLE || line >= `V_VISIBLE) begin
			return '0;
		end
		c = col[7:0] ^ {8{fl}};
		l = line[7:0] ^ {8{fl}};
		code = vram_sh[{1'b0, l[7:3], c[7:3]}];
		attr = attr_at(col, line, fl);
		px = c[2:0] ^ {3{attr.hflip}};
		ln = l[2:0] ^ {3{attr.vflip}};
		rb = trom_sh[{attr.bank, code, px[2], ln}];
		// Upper plane bit n+4, lower plane bit n
		pix = {rb[{1'b1, px[1:0]}], rb[{1'b0, px[1:0]}]};
		lut = tlut_sh[{attr.colour, pix}];
		idx = attr.prio ? {1'b1, lut} : 5'd0;
		return cprom_sh[idx];
	endfunction

	// =========================================================================
	// Stimulus helpers
	// =========================================================================

	task automatic flag_error(input string msg);
		if (printed < MAX_PRINT) begin
			$display("** Error at %0t ns: %s", $time, msg);
		end
		printed++;
	endtask

	task automatic download(input int sel, input int depth);
		for (int a = 0; a < depth; a++) begin
			@(posedge clk_49m);
			rng = xorshift(rng);
			dl <= {13'(a), rng[7:0], 1'b1};
			trom_cs <= (sel == 0);
			tlut_cs <= (sel == 1);
			cprom_cs <= (sel == 2);
			if (sel == 0) trom_sh[a] = rng[7:0];
			if (sel == 1) tlut_sh[a] = rng[3:0];
			if (sel == 2) cprom_sh[a] = rng[7:0];
		end
		@(posedge clk_49m);
		dl.wr <= 1'b0;
		trom_cs <= 1'b0;
		tlut_cs <= 1'b0;
		cprom_cs <= 1'b0;
	endtask

	// One strobe, then the minimum spacing
	task automatic host_write(input logic [11:0] addr, input logic [7:0] data);
		@(posedge clk_49m);
		host <= {addr, data, 1'b1};
		@(posedge clk_49m);
		host.wr <= 1'b0;
		if (addr[11]) begin
			flip_sh = data[0];
		end else begin
			vram_sh[addr[10:0]] = data;
		end
		repeat (32) @(posedge clk_49m);
	endtask

	task automatic check_reset_state(input bit after);
		if (rgb != '0) begin
			reset_errs++;
			flag_error("rgb_o not zero around reset");
		end
		if (!hsync_n || !vsync_n || ce_pix || hblank || vblank) begin
			reset_errs++;
			flag_error("control outputs not at reset values");
		end
		if (after && dut.flip !== 1'b0) begin
			reset_errs++;
			flag_error("flip latch not clear after reset");
		end
	endtask

	task automatic report_test(input int num, input string name, input int errs);
		if (errs == 0) begin
			tests_passed++;
			$display("test %0d %s: pass", num, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: fail with %0d errors", num, name, errs);
		end
	endtask

	// =========================================================================
	// Compare process sampling on the falling edge
	// =========================================================================
	always @(negedge clk_49m) begin
		rgb_t       exp;
		tile_attr_t at;
		int         fi;
		if (!reset) begin
			cur_h = 0;
			cur_v = 0;
			smp_valid = 0;
			ce_seen = 0;
			clk_gap = 0;
		end else begin
			clk_gap++;
			if (ce_pix) begin
				if (ce_seen && clk_gap != `PIX_DIV) begin
					timing_errs++;
					flag_error($sformatf("ce_pix spacing %0d", clk_gap));
				end
				clk_gap = 0;
				ce_seen = 1;
				// Syncs follow the live counter
				if (hsync_n != !(cur_h >= `HSYNC_START && cur_h < `HSYNC_END)) begin
					timing_errs++;
					flag_error($sformatf("hsync wrong at h %0d", cur_h));
				end
				if (vsync_n != !(cur_v >= `VSYNC_START && cur_v < `VSYNC_END)) begin
					timing_errs++;
					flag_error($sformatf("vsync wrong at v %0d", cur_v));
				end
				// Frame length between vsync falls
				if (vsync_prev && !vsync_n) begin
					if (cens_valid && frame_cens != `H_TOTAL * `V_TOTAL) begin
						timing_errs++;
						flag_error($sformatf("frame of %0d pixels", frame_cens));
					end
					frame_cens = 0;
					cens_valid = 1;
				end
				frame_cens++;
				vsync_prev = vsync_n;
				if (smp_valid) begin
					if (smp_h == 0 && smp_v == 0) begin
						frame_cnt++;
					end
					if (hblank != (smp_h >= `H_VISIBLE) || vblank != (smp_v >= `V_VISIBLE)) begin
						timing_errs++;
						flag_error($sformatf("blank wrong at (%0d,%0d)", smp_h, smp_v));
					end
					if ((hblank || vblank) && rgb != '0) begin
						blank_errs++;
						flag_error($sformatf("rgb not black at (%0d,%0d)", smp_h, smp_v));
					end
					if (chk_start > 0 && frame_cnt >= chk_start) begin
						fi = (frame_cnt < 16) ? frame_cnt : 15;
						exp = ref_rgb(smp_h, smp_v, flip_sh);
						if (rgb != exp) begin
							frame_errs[fi]++;
							flag_error($sformatf("pixel (%0d,%0d) got %h expected %h",
								smp_h, smp_v, rgb, exp));
						end
						// Background entry where the tile has no priority
						at = attr_at(smp_h, smp_v, flip_sh);
						if (frame_cnt == chk_start && smp_h < `H_VISIBLE &&
							smp_v < `V_VISIBLE && !at.prio) begin
							prio0_cnt++;
							if (rgb != cprom_sh[0]) begin
								prio0_errs++;
								flag_error($sformatf("pixel (%0d,%0d) got %h not background %h",
									smp_h, smp_v, rgb, cprom_sh[0]));
							end
						end
					end
				end
				smp_h = cur_h;
				smp_v = cur_v;
				smp_valid = 1;
				if (cur_h == `H_TOTAL - 1) begin
					cur_h = 0;
					cur_v = (cur_v == `V_TOTAL - 1) ? 0 : cur_v + 1;
				end else begin
					cur_h++;
				end
			end
		end
	end

	// =========================================================================
	// Test sequence
	// =========================================================================
	initial begin
		int target;
		host = '0;
		dl = '0;
		trom_cs = 1'b0;
		tlut_cs = 1'b0;
		cprom_cs = 1'b0;
		flip_sh = 1'b0;
		rng = 32'hdbae_dc16;
		vsync_prev = 1'b1;
		chk_start = 0;
		for (int i = 0; i < 16; i++) begin
			frame_errs[i] = 0;
		end

		@(negedge clk_49m);
		check_reset_state(0);
		wait (reset);
		@(negedge clk_49m);
		check_reset_state(1);

		download(0, 2**`TROM_AW);
		download(1, 2**`LUT_AW);
		download(2, 2**`CPROM_AW);
		for (int a = 0; a < 2**`VRAM_AW; a++) begin
			rng = xorshift(rng);
			host_write(12'(a), rng[7:0]);
		end

		// Frame with flip clear, flip set in its vblank
		target = frame_cnt + 1;
		chk_start = target;
		wait (frame_cnt == target);
		wait (cur_v == HOST_LINE);
		host_write(12'h800, 8'h01);
		wait (frame_cnt == target + 1);
		report_test(1, "raster timing", timing_errs);
		report_test(2, "frame without flip", frame_errs[target]);
		report_test(4, "priority clear", prio0_errs + ((prio0_cnt == 0) ? 1 : 0));

		// Flipped frame, new tile codes written in its vblank
		target++;
		wait (cur_v == HOST_LINE);
		for (int c = 3; c < 6; c++) begin
			host_write({1'b0, 1'b0, 5'd10, 5'(c)}, vram_sh[{1'b0, 5'd10, 5'(c)}] ^ 8'h5a);
			// Priority set so the new tile reaches the screen
			host_write({1'b0, 1'b1, 5'd10, 5'(c)}, vram_sh[{1'b1, 5'd10, 5'(c)}] | 8'h10);
		end
		wait (frame_cnt == target + 1);
		report_test(3, "frame with flip", frame_errs[target]);

		target++;
		wait (frame_cnt == target + 1);
		report_test(5, "vram write in vblank", frame_errs[target]);
		report_test(6, "reset and blanking", reset_errs + blank_errs);

		$display("%0d tests passed, %0d failed, %0d errors", tests_passed, tests_failed, printed);
		if (tests_failed == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(WATCHDOG);
		$display("Watchdog expired before the frame checks finished");
		$display("TEST FAILED");
		$finish;
	end

endmodule

/* list.f */
+incdir+rtl
rtl/video_pkg.sv
rtl/bus_pkg.sv
rtl/dl_rom.sv
rtl/video_timing.sv
rtl/host_bus.sv
rtl/tile_layer.sv
rtl/color_output.sv
rtl/gyruss_video_top.sv
sim/tb_clock.sv
sim/gyruss_sva.sv
sim/tb_top.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert -Wno-fatal --top-module tb_top -f list.f
out=$(./obj_dir/Vtb_top)
echo "$out"
echo "$out" | grep -q "TEST PASSED"
